/* rtl/flag_pkg.sv */
package flag_pkg;

    // operation codes accepted by the flag unit
    typedef enum logic [3:0] {
        op_nop,  // no effect
        op_adc,  // a + b + C, updates N Z C V
        op_sbc,  // a - b - ~C, updates N Z C V
        op_ld,   // b onto bus, updates N Z
        op_plp,  // b into all flags
        op_clc,
        op_sec,
        op_cli,
        op_sei,
        op_cld,
        op_sed,
        op_clv,
        op_brk,  // sets I, break bits up while acked
        op_br    // branch test only
    } flag_op_t;

    // upper two bits pick the flag, bit 0 is the value that means taken
    typedef enum logic [2:0] {
        bpl,  // N == 0
        bmi,  // N == 1
        bvc,  // V == 0
        bvs,  // V == 1
        bcc,  // C == 0
        bcs,  // C == 1
        bne,  // Z == 0
        beq   // Z == 1
    } branch_cond_t;

    // bit positions in the status byte
    localparam int flag_c = 0;
    localparam int flag_z = 1;
    localparam int flag_i = 2;
    localparam int flag_d = 3;
    localparam int flag_v = 6;
    localparam int flag_n = 7;

endpackage

/* rtl/flag_alu.sv */
module flag_alu (
    input  flag_pkg::flag_op_t op,
    input  logic [7:0]         a,
    input  logic [7:0]         b,
    input  logic               carry_in,  // held C flag
    output logic [7:0]         sum,
    output logic               carry,
    output logic               overflow
);
    import flag_pkg::*;

    logic [7:0] b_eff;  // b, inverted for subtract
    logic [8:0] total;  // 9 bits to catch carry out

    always_comb begin
        b_eff = (op == op_sbc) ? ~b : b;
        total = {1'b0, a} + {1'b0, b_eff} + {8'h00, carry_in};
    end

    always_comb begin
        if (op == op_adc || op == op_sbc) begin
            sum   = total[7:0];
            carry = total[8];  // on sbc, 1 means no borrow
            // signed overflow: operands agree in sign, result does not
            overflow = (a[7] == b_eff[7]) && (total[7] != a[7]);
        end else begin
            sum      = b;     // load operand straight through
            carry    = 1'b0;
            overflow = 1'b0;  // clv relies on this being 0
        end
    end

endmodule

/* rtl/flag_decoder.sv */
module flag_decoder (
    input  logic               clk,
    input  logic               nrst,
    input  logic               req,
    input  flag_pkg::flag_op_t op,
    input  logic [7:0]         b,
    input  logic [7:0]         sum,   // from the ALU
    output logic               ack,
    output logic               accept,  // one-cycle take strobe
    output logic [7:0]         result,
    output logic [7:0]         db,      // bus byte into the status reg
    output logic               manual_set,
    output logic               db_c,
    output logic               db_z,
    output logic               db_i,
    output logic               db_d,
    output logic               db_v,
    output logic               db_n,
    output logic               manual_c,
    output logic               manual_i,
    output logic               manual_d,
    output logic               carry_c,
    output logic               dball_z,
    output logic               overflow_v,
    output logic               set_v,
    output logic               break_set
);
    import flag_pkg::*;

    assign accept = req & ~ack;  // new request, not yet acknowledged

    // bus source: pulled byte, zero for clv, else the ALU byte
    always_comb begin
        if (op == op_plp) begin
            db = b;
        end else if (op == op_clv) begin
            db = 8'h00;
        end else begin
            db = sum;  // ALU result, or b passed through
        end
    end

    assign set_v = 1'b0;  // nothing here sets V directly

    // write enables, only live in the accept cycle
    always_comb begin
        manual_set = 1'b0;
        db_c       = 1'b0;
        db_z       = 1'b0;
        db_i       = 1'b0;
        db_d       = 1'b0;
        db_v       = 1'b0;
        db_n       = 1'b0;
        manual_c   = 1'b0;
        manual_i   = 1'b0;
        manual_d   = 1'b0;
        carry_c    = 1'b0;
        dball_z    = 1'b0;
        overflow_v = 1'b0;
        if (accept) begin
            case (op)
                op_adc, op_sbc: begin
                    carry_c    = 1'b1;
                    overflow_v = 1'b1;
                    dball_z    = 1'b1;  // zero detect on sum
                    db_n       = 1'b1;  // sign from sum bit 7
                end
                op_ld: begin
                    dball_z = 1'b1;
                    db_n    = 1'b1;
                end
                op_plp: begin
                    db_c = 1'b1;
                    db_z = 1'b1;
                    db_i = 1'b1;
                    db_d = 1'b1;
                    db_v = 1'b1;
                    db_n = 1'b1;
                end
                op_clc: manual_c = 1'b1;
                op_sec: begin
                    manual_c   = 1'b1;
                    manual_set = 1'b1;
                end
                op_cli: manual_i = 1'b1;
                op_sei, op_brk: begin  // brk also masks interrupts
                    manual_i   = 1'b1;
                    manual_set = 1'b1;
                end
                op_cld: manual_d = 1'b1;
                op_sed: begin
                    manual_d   = 1'b1;
                    manual_set = 1'b1;
                end
                op_clv: overflow_v = 1'b1;  // ALU overflow is 0 here
                default: ;                  // nop, br
            endcase
        end
    end

    // ack, result and break bits held for the whole ack phase
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ack       <= 1'b0;
            result    <= 8'h00;
            break_set <= 1'b0;
        end else if (accept) begin
            ack       <= 1'b1;
            result    <= db;
            break_set <= (op == op_brk);
        end else if (!req) begin
            ack       <= 1'b0;  // req dropped, close the handshake
            break_set <= 1'b0;
        end
    end

endmodule

/* rtl/status_reg.sv */
module status_reg (
    input  logic       clk,
    input  logic       nrst,
    input  logic [7:0] db,          // bus byte
    input  logic       manual_set,  // value for manual_* writes
    input  logic       carry,       // ALU carry
    input  logic       overflow,    // ALU overflow
    input  logic       db_c,        // db_* take the matching bus bit
    input  logic       db_z,
    input  logic       db_i,
    input  logic       db_d,
    input  logic       db_v,
    input  logic       db_n,
    input  logic       manual_c,
    input  logic       manual_i,
    input  logic       manual_d,
    input  logic       carry_c,     // C from ALU
    input  logic       dball_z,     // Z from zero detect on bus
    input  logic       overflow_v,  // V from ALU
    input  logic       set_v,       // direct set of V
    input  logic       break_set,
    output logic [7:0] flags,
    output logic [7:0] status
);
    import flag_pkg::*;

    logic [7:0] flag_q;
    logic [7:0] flag_nxt;

    // unwritten flags keep their value
    always_comb begin
        flag_nxt = flag_q;
        if (db_c)           flag_nxt[flag_c] = db[flag_c];
        else if (manual_c)  flag_nxt[flag_c] = manual_set;
        else if (carry_c)   flag_nxt[flag_c] = carry;

        if (db_z)           flag_nxt[flag_z] = db[flag_z];
        else if (dball_z)   flag_nxt[flag_z] = ~|db;

        if (db_i)           flag_nxt[flag_i] = db[flag_i];
        else if (manual_i)  flag_nxt[flag_i] = manual_set;

        if (db_d)           flag_nxt[flag_d] = db[flag_d];
        else if (manual_d)  flag_nxt[flag_d] = manual_set;

        if (db_v)            flag_nxt[flag_v] = db[flag_v];
        else if (overflow_v) flag_nxt[flag_v] = overflow;
        else if (set_v)      flag_nxt[flag_v] = 1'b1;

        if (db_n)           flag_nxt[flag_n] = db[flag_n];

        flag_nxt[5:4] = 2'b00;  // no storage behind the break bits
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            flag_q <= 8'h00;
        end else begin
            flag_q <= flag_nxt;
        end
    end

    assign flags  = flag_q;
    // break bits only show in the pushed/visible byte
    assign status = {flag_q[7:6], break_set, break_set, flag_q[3:0]};

endmodule

/* rtl/branch_eval.sv */
module branch_eval (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   accept,
    input  flag_pkg::branch_cond_t cond,
    input  logic [7:0]             flags,  // held flags, before update
    output logic                   taken
);
    import flag_pkg::*;

    logic sel_flag;
    logic hit;

    always_comb begin
        case (cond[2:1])
            2'd0:    sel_flag = flags[flag_n];  // bpl / bmi
            2'd1:    sel_flag = flags[flag_v];  // bvc / bvs
            2'd2:    sel_flag = flags[flag_c];  // bcc / bcs
            default: sel_flag = flags[flag_z];  // bne / beq
        endcase
        hit = (sel_flag == cond[0]);
    end

    // held until the next accepted operation
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            taken <= 1'b0;
        end else if (accept) begin
            taken <= hit;
        end
    end

endmodule

/* rtl/flag_unit_top.sv */
module flag_unit_top (
    input  logic                   clk,
    input  logic                   nrst,
    input  logic                   req,
    input  flag_pkg::flag_op_t     op,
    input  logic [7:0]             a,
    input  logic [7:0]             b,
    input  flag_pkg::branch_cond_t cond,
    output logic                   ack,
    output logic [7:0]             status,
    output logic [7:0]             result,
    output logic                   taken
);
    import flag_pkg::*;

    logic       accept;
    logic [7:0] db;
    logic [7:0] sum;
    logic [7:0] flags;
    logic       carry, overflow;   // ALU flags to status reg
    logic       manual_set;
    logic       db_c, db_z, db_i, db_d, db_v, db_n;
    logic       manual_c, manual_i, manual_d;
    logic       carry_c, dball_z, overflow_v, set_v;
    logic       break_set;

    flag_decoder flag_decoder_i (
        .clk(clk), .nrst(nrst), .req(req), .op(op), .b(b), .sum(sum),
        .ack(ack), .accept(accept), .result(result), .db(db),
        .manual_set(manual_set),
        .db_c(db_c), .db_z(db_z), .db_i(db_i), .db_d(db_d), .db_v(db_v), .db_n(db_n),
        .manual_c(manual_c), .manual_i(manual_i), .manual_d(manual_d),
        .carry_c(carry_c), .dball_z(dball_z), .overflow_v(overflow_v), .set_v(set_v),
        .break_set(break_set)
    );

    flag_alu flag_alu_i (
        .op(op), .a(a), .b(b),
        .carry_in(flags[flag_c]),  // adc/sbc chain off held C
        .sum(sum), .carry(carry), .overflow(overflow)
    );

    status_reg status_reg_i (
        .clk(clk), .nrst(nrst), .db(db), .manual_set(manual_set),
        .carry(carry), .overflow(overflow),
        .db_c(db_c), .db_z(db_z), .db_i(db_i), .db_d(db_d), .db_v(db_v), .db_n(db_n),
        .manual_c(manual_c), .manual_i(manual_i), .manual_d(manual_d),
        .carry_c(carry_c), .dball_z(dball_z), .overflow_v(overflow_v), .set_v(set_v),
        .break_set(break_set),
        .flags(flags), .status(status)
    );

    branch_eval branch_eval_i (
        .clk(clk), .nrst(nrst), .accept(accept), .cond(cond),
        .flags(flags), .taken(taken)
    );

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk
);

    // free running, period 8
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

/* dv/flag_unit_tb.sv */
module flag_unit_tb;
    import flag_pkg::*;

    // one row per handshake, expected values taken while ack is high
    typedef struct packed {
        flag_op_t     op;
        logic [7:0]   a;
        logic [7:0]   b;
        branch_cond_t cond;
        int           hold;    // extra cycles req stays up after ack
        logic [7:0]   status;
        logic [7:0]   result;
        logic         taken;   // from flags before the update
    } entry_t;

    logic         clk;
    logic         nrst;
    logic         req;
    flag_op_t     op;
    logic [7:0]   a;
    logic [7:0]   b;
    branch_cond_t cond;
    logic         ack;
    logic [7:0]   status;
    logic [7:0]   result;
    logic         taken;

    entry_t tab[$];
    int     errors = 0;
    int     passed = 0;
    int     failed = 0;
    int     cycles = 0;
    int     max_cycles = 1000;  // replaced once the table is built

    tb_clk_gen clk_gen_i (.clk(clk));

    flag_unit_top flag_unit_top_i (
        .clk(clk), .nrst(nrst), .req(req), .op(op), .a(a), .b(b), .cond(cond),
        .ack(ack), .status(status), .result(result), .taken(taken)
    );

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: handshakes did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic entry_t row(input flag_op_t o, input logic [7:0] x,
                                   input logic [7:0] y, input branch_cond_t c,
                                   input int h, input logic [7:0] st,
                                   input logic [7:0] res, input logic tk);
        entry_t e;
        e.op     = o;
        e.a      = x;
        e.b      = y;
        e.cond   = c;
        e.hold   = h;
        e.status = st;
        e.result = res;
        e.taken  = tk;
        return e;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] exp,
                              input logic [7:0] act);
        assert (act === exp) else begin
            $display("FAILED at %0t: %s expected %02h got %02h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic run_entry(input int idx, input entry_t e);
        int edges;
        int h;
        int errs_before;
        errs_before = errors;
        @(posedge clk);
        req  <= 1'b1;
        op   <= e.op;
        a    <= e.a;
        b    <= e.b;
        cond <= e.cond;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);  // sample away from the edge
        end while (!ack);
        assert (edges == 1) else begin
            $display("FAILED at %0t: ack rose %0d edges after req instead of 1", $time, edges);
            errors++;
        end
        check_byte("status", e.status, status);
        check_byte("result", e.result, result);
        check_byte("taken", {7'd0, e.taken}, {7'd0, taken});
        // req held, outputs must stay put and no second update
        for (h = 0; h < e.hold; h++) begin
            @(negedge clk);
            check_byte("ack", 8'h01, {7'd0, ack});
            check_byte("status", e.status, status);
            check_byte("result", e.result, result);
            check_byte("taken", {7'd0, e.taken}, {7'd0, taken});
        end
        @(posedge clk);
        req <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end while (ack);
        assert (edges == 1) else begin
            $display("FAILED at %0t: ack fell %0d edges after req dropped instead of 1",
                     $time, edges);
            errors++;
        end
        if (errors == errs_before) begin
            passed++;
            $display("entry %0d %s: ok", idx, e.op.name());
        end else begin
            failed++;
            $display("entry %0d %s: %0d error(s)", idx, e.op.name(), errors - errs_before);
        end
    endtask

    initial begin
        int errs_before;
        nrst <= 1'b0;
        req  <= 1'b0;
        op   <= op_nop;
        a    <= 8'h00;
        b    <= 8'h00;
        cond <= bpl;

        // arithmetic, status = N V b b D I Z C
        tab.push_back(row(op_adc, 8'h50, 8'h50, bpl, 0, 8'hC0, 8'hA0, 1'b1));  // N V
        tab.push_back(row(op_adc, 8'hFF, 8'h01, bmi, 0, 8'h03, 8'h00, 1'b1));  // Z C
        tab.push_back(row(op_sbc, 8'h05, 8'h03, bvs, 0, 8'h01, 8'h02, 1'b0));  // no borrow
        tab.push_back(row(op_sbc, 8'h03, 8'h05, bcs, 0, 8'h80, 8'hFE, 1'b1));  // borrow
        // set / clear, others held
        tab.push_back(row(op_sec, 8'h00, 8'h00, bcc, 0, 8'h81, 8'h00, 1'b1));
        tab.push_back(row(op_sed, 8'h00, 8'h00, bne, 0, 8'h89, 8'h00, 1'b1));
        tab.push_back(row(op_sei, 8'h00, 8'h00, beq, 0, 8'h8D, 8'h00, 1'b0));
        tab.push_back(row(op_clc, 8'h00, 8'h00, bvc, 0, 8'h8C, 8'h00, 1'b1));
        tab.push_back(row(op_cld, 8'h00, 8'h00, bpl, 0, 8'h84, 8'h00, 1'b0));
        tab.push_back(row(op_cli, 8'h00, 8'h00, bmi, 0, 8'h80, 8'h00, 1'b1));
        tab.push_back(row(op_plp, 8'h00, 8'hC3, bcs, 0, 8'hC3, 8'hC3, 1'b0));  // 5:4 read 0
        tab.push_back(row(op_clv, 8'h00, 8'hFF, bvs, 0, 8'h83, 8'h00, 1'b1));  // bus forced 0
        tab.push_back(row(op_ld,  8'h00, 8'h00, beq, 0, 8'h03, 8'h00, 1'b1));  // Z up, N down
        // break bits only while acked
        tab.push_back(row(op_brk, 8'h00, 8'h00, bne, 0, 8'h37, 8'h00, 1'b0));
        tab.push_back(row(op_nop, 8'h00, 8'h00, bcc, 0, 8'h07, 8'h00, 1'b0));
        // all eight conditions on N=0 V=0 Z=1 C=1
        tab.push_back(row(op_br, 8'h00, 8'h5A, bpl, 0, 8'h07, 8'h5A, 1'b1));
        tab.push_back(row(op_br, 8'h00, 8'h5A, bmi, 0, 8'h07, 8'h5A, 1'b0));
        tab.push_back(row(op_br, 8'h00, 8'h5A, bvc, 0, 8'h07, 8'h5A, 1'b1));
        tab.push_back(row(op_br, 8'h00, 8'h5A, bvs, 0, 8'h07, 8'h5A, 1'b0));
        tab.push_back(row(op_br, 8'h00, 8'h5A, bcc, 0, 8'h07, 8'h5A, 1'b0));
        tab.push_back(row(op_br, 8'h00, 8'h5A, bcs, 0, 8'h07, 8'h5A, 1'b1));
        tab.push_back(row(op_br, 8'h00, 8'h5A, bne, 0, 8'h07, 8'h5A, 1'b0));
        tab.push_back(row(op_br, 8'h00, 8'h5A, beq, 0, 8'h07, 8'h5A, 1'b1));
        // held req, a second adc would give result 7F and drop N V
        tab.push_back(row(op_adc, 8'h7F, 8'h00, bcs, 2, 8'hC4, 8'h80, 1'b1));
        tab.push_back(row(op_br,  8'h00, 8'h00, bcc, 0, 8'hC4, 8'h00, 1'b1));

        max_cycles = 8 + 6 * tab.size() + 20;

        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        errs_before = errors;
        check_byte("status", 8'h00, status);
        check_byte("ack", 8'h00, {7'd0, ack});
        if (errors == errs_before) begin
            passed++;
            $display("reset: ok");
        end else begin
            failed++;
            $display("reset: %0d error(s)", errors - errs_before);
        end

        foreach (tab[i]) begin
            run_entry(i, tab[i]);
        end

        $display("%0d passed, %0d failed", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
rtl/flag_pkg.sv
rtl/flag_alu.sv
rtl/flag_decoder.sv
rtl/status_reg.sv
rtl/branch_eval.sv
rtl/flag_unit_top.sv
dv/tb_clk_gen.sv
dv/flag_unit_tb.sv

/* Bender.yml */
package:
  name: flag_unit

sources:
  - rtl/flag_pkg.sv
  - rtl/flag_alu.sv
  - rtl/flag_decoder.sv
  - rtl/status_reg.sv
  - rtl/branch_eval.sv
  - rtl/flag_unit_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/flag_unit_tb.sv
